// ==== mult_unit.f ====
+incdir+design
design/mult_pkg.sv
design/mult_decode.sv
design/mult_control.sv
design/booth_datapath.sv
design/mult_result.sv
design/mult_unit.sv
sim/mult_assertions.sv
sim/mult_checker.sv
sim/mult_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the booth multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f mult_unit.f \
  --top-module mult_unit_tb

# keep going after an assertion error so the closing report is printed
./obj_dir/Vmult_unit_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result line, see sim.log"
  exit 1
fi
echo "simulation passed"

// ==== sim/mult_unit_tb.sv ====
// testbench top, clock, reset, stimulus, DUT, checker, bind, watchdog and reference product
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_unit_tb;

  localparam int N_DIRECTED  = 18;
  localparam int N_RANDOM    = 32;
  localparam int N_TESTS     = N_DIRECTED + N_RANDOM;
  localparam int CYCLE_LIMIT = N_TESTS * (`MULT_LATENCY + 2) + 200;
  localparam int TAG_W       = `MULT_TAG_WIDTH;

  logic                       mclk;
  logic                       rst_n;
  logic                       cmd_valid;
  mult_pkg::mult_cmd_t        cmd;
  wire                        busy;
  wire                        res_valid;
  mult_pkg::mult_res_t        res;
  logic [2*`MULT_WIDTH-1:0]   exp_product;
  int                         mismatch_count;
  int                         unexpected_count;
  int                         pending_count;
  int                         stim_errors;
  int                         cycle_count;
  int                         seed;
  int                         i;
  logic [`MULT_TAG_WIDTH-1:0] next_tag;
  logic [31:0]                r;

  // both operands taken to 64 bits, the low 64 bits of the product are then exact
  function automatic logic [2*`MULT_WIDTH-1:0] ref_product(
    input mult_pkg::mult_op_e     op,
    input logic [`MULT_WIDTH-1:0] a,
    input logic [`MULT_WIDTH-1:0] b);
    logic [2*`MULT_WIDTH-1:0] a64;
    logic [2*`MULT_WIDTH-1:0] b64;
    if (op == mult_pkg::op_mult) begin
      a64 = {{`MULT_WIDTH{a[`MULT_WIDTH-1]}}, a};
      b64 = {{`MULT_WIDTH{b[`MULT_WIDTH-1]}}, b};
    end else begin
      a64 = {{`MULT_WIDTH{1'b0}}, a};
      b64 = {{`MULT_WIDTH{1'b0}}, b};
    end
    return a64 * b64;
  endfunction

  assign exp_product = ref_product(cmd.op, cmd.a, cmd.b);

  always #5 mclk = ~mclk;

  mult_unit mult_unit_i (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .res_valid (res_valid),
    .res       (res)
  );

  mult_checker checker_i (
    .mclk             (mclk),
    .rst_n            (rst_n),
    .cmd_valid        (cmd_valid),
    .cmd              (cmd),
    .exp_product      (exp_product),
    .busy             (busy),
    .res_valid        (res_valid),
    .res              (res),
    .mismatch_count   (mismatch_count),
    .unexpected_count (unexpected_count),
    .pending_count    (pending_count)
  );

  bind mult_unit mult_assertions assertions_i (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .res_valid (res_valid),
    .res       (res)
  );

  // called 1 ns after an edge, waits for an idle unit then strobes once
  task automatic issue_cmd(input mult_pkg::mult_op_e op, input logic [31:0] a,
                           input logic [31:0] b);
    while (busy) begin
      @(posedge mclk);
      #1;
    end
    cmd_valid = 1'b1;
    cmd.op    = op;
    cmd.a     = a;
    cmd.b     = b;
    cmd.tag   = next_tag;
    next_tag  = next_tag + TAG_W'(1);
    @(posedge mclk);
    #1;
    cmd_valid = 1'b0;
  endtask

  // strobe that the unit must drop, it is still working on the last command
  task automatic strobe_while_busy(input int wait_cycles);
    repeat (wait_cycles) begin
      @(posedge mclk);
      #1;
    end
    if (!busy) begin
      stim_errors++;
      $display("stray strobe at %0t found the unit idle instead of busy", $time);
    end else begin
      cmd_valid = 1'b1;
      cmd.a     = $random(seed);
      cmd.b     = $random(seed);
      cmd.tag   = ~next_tag;
      @(posedge mclk);
      #1;
      cmd_valid = 1'b0;
    end
  endtask

  task automatic end_run(input bit timed_out);
    int total;
    if (pending_count != 0)
      $display("missing results: %0d accepted commands never returned", pending_count);
    total = mismatch_count + unexpected_count + pending_count + stim_errors
          + mult_unit_i.assertions_i.fail_count + int'(timed_out);
    $write("errors: %0d mismatch, %0d unexpected, %0d missing, ",
           mismatch_count, unexpected_count, pending_count);
    $display("%0d stimulus, %0d assertion, %0d timeout",
             stim_errors, mult_unit_i.assertions_i.fail_count, int'(timed_out));
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge mclk);
      cycle_count++;
    end
    $display("run timed out after %0d cycles", CYCLE_LIMIT);
    end_run(1'b1);
  end

  initial begin : stimulus
    mclk        = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    next_tag    = '0;
    stim_errors = 0;
    seed        = 43358;
    repeat (5) @(posedge mclk);
    #1 rst_n = 1'b1;
    @(posedge mclk);
    #1;
    // signed, sign combinations and the most negative value
    issue_cmd(mult_pkg::op_mult, 32'hFFFF_FFFB, 32'h0000_0007);
    strobe_while_busy(0);  // right behind the accepted strobe
    issue_cmd(mult_pkg::op_mult, 32'hFFFF_FFFD, 32'hFFFF_FFF7);
    issue_cmd(mult_pkg::op_mult, 32'h8000_0000, 32'h8000_0000);
    issue_cmd(mult_pkg::op_mult, 32'h7FFF_FFFF, 32'h8000_0000);
    issue_cmd(mult_pkg::op_mult, 32'h1234_5678, 32'hFEDC_BA98);
    strobe_while_busy(10);
    // unsigned with top bits set, zero extension must win over the sign
    issue_cmd(mult_pkg::op_multu, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    issue_cmd(mult_pkg::op_multu, 32'h8000_0000, 32'h8000_0000);
    issue_cmd(mult_pkg::op_multu, 32'hDEAD_BEEF, 32'hCAFE_F00D);
    issue_cmd(mult_pkg::op_multu, 32'hFFFF_FFFB, 32'h0000_0007);
    strobe_while_busy(33);  // last busy cycle
    // corner operands
    issue_cmd(mult_pkg::op_mult, 32'h0000_0000, 32'hFFFF_FFFF);
    issue_cmd(mult_pkg::op_multu, 32'h0000_0001, 32'hFFFF_FFFF);
    issue_cmd(mult_pkg::op_mult, 32'h0000_0001, 32'hFFFF_FFFF);
    issue_cmd(mult_pkg::op_mult, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    issue_cmd(mult_pkg::op_mult, 32'h5555_5555, 32'hAAAA_AAAA);
    issue_cmd(mult_pkg::op_multu, 32'h5555_5555, 32'hAAAA_AAAA);
    issue_cmd(mult_pkg::op_multu, 32'hAAAA_AAAA, 32'hAAAA_AAAA);
    issue_cmd(mult_pkg::op_mult, 32'hAAAA_AAAA, 32'h5555_5555);
    issue_cmd(mult_pkg::op_multu, 32'h0000_0000, 32'h0000_0000);
    for (i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      issue_cmd(mult_pkg::mult_op_e'(r[0]), $random(seed), $random(seed));
      if (i % 8 == 3) strobe_while_busy(i % 30);
    end
    // drain, then give a stray result time to show up
    while (pending_count != 0) begin
      @(posedge mclk);
      #1;
    end
    repeat (`MULT_LATENCY + 2) @(posedge mclk);
    end_run(1'b0);
  end

endmodule

`default_nettype wire

// ==== sim/mult_checker.sv ====
// result checker, queue of accepted commands, product, tag and latency compare
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_checker (
  input  wire                            mclk,
  input  wire                            rst_n,
  input  wire                            cmd_valid,
  input  wire mult_pkg::mult_cmd_t       cmd,
  input  wire [2*`MULT_WIDTH-1:0]        exp_product,  // reference for the command on the port
  input  wire                            busy,
  input  wire                            res_valid,
  input  wire mult_pkg::mult_res_t       res,
  output int                             mismatch_count,
  output int                             unexpected_count,
  output int                             pending_count     // accepted, no result yet
);

  // strobe sampled at edge 0, result sampled at edge MULT_LATENCY + 1
  localparam int SEEN_GAP = `MULT_LATENCY + 1;

  logic [2*`MULT_WIDTH-1:0]   exp_q[$];
  logic [`MULT_TAG_WIDTH-1:0] tag_q[$];
  int                         cycle_q[$];  // edge on which each command was taken
  int                         cycle;
  logic [2*`MULT_WIDTH-1:0]   exp_val;
  logic [`MULT_TAG_WIDTH-1:0] exp_tag;
  int                         taken_at;

  always @(posedge mclk) begin
    if (!rst_n) begin
      cycle = 0;
      exp_q.delete();
      tag_q.delete();
      cycle_q.delete();
      mismatch_count   = 0;
      unexpected_count = 0;
      pending_count    = 0;
    end else begin
      cycle = cycle + 1;
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          unexpected_count++;
          $display("unexpected result at %0t: tag %0h with no command outstanding",
                   $time, res.tag);
        end else begin
          exp_val  = exp_q.pop_front();
          exp_tag  = tag_q.pop_front();
          taken_at = cycle_q.pop_front();
          if ({res.hi, res.lo} !== exp_val) begin
            mismatch_count++;
            $display("Mismatch at %0t: product %h_%h, expected %h (tag %0h)",
                     $time, res.hi, res.lo, exp_val, exp_tag);
          end
          if (res.tag !== exp_tag) begin
            mismatch_count++;
            $display("Mismatch at %0t: tag %0h, expected %0h", $time, res.tag, exp_tag);
          end
          if (cycle - taken_at != SEEN_GAP) begin
            mismatch_count++;
            $display("Mismatch at %0t: result after %0d cycles, expected %0d",
                     $time, cycle - taken_at, SEEN_GAP);
          end
        end
      end
      // same rule as decode, strobes during busy are not commands
      if (cmd_valid && !busy) begin
        exp_q.push_back(exp_product);
        tag_q.push_back(cmd.tag);
        cycle_q.push_back(cycle);
      end
      pending_count = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// ==== sim/mult_assertions.sv ====
// concurrent assertions on the top-level strobes of the booth multiplier unit
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_assertions (
  input wire                       mclk,
  input wire                       rst_n,
  input wire                       cmd_valid,
  input wire mult_pkg::mult_cmd_t  cmd,
  input wire                       busy,
  input wire                       res_valid,
  input wire mult_pkg::mult_res_t  res
);

  // strobe sampled at edge 0, res_valid raised by edge MULT_LATENCY and seen one edge later
  localparam int SEEN_GAP = `MULT_LATENCY + 1;

  logic accepted;
  int   fail_count = 0;  // read by the testbench for its closing line

  assign accepted = cmd_valid & ~busy;

  // one result per accepted command, at the fixed latency, and no other
  latency_a: assert property (@(posedge mclk) disable iff (!rst_n)
    res_valid == $past(accepted, SEEN_GAP))
    else begin
      $error("res_valid does not line up with an accepted command");
      fail_count++;
    end

  tag_a: assert property (@(posedge mclk) disable iff (!rst_n)
    res_valid |-> res.tag == $past(cmd.tag, SEEN_GAP))
    else begin
      $error("result tag differs from the accepted command tag");
      fail_count++;
    end

  pulse_a: assert property (@(posedge mclk) disable iff (!rst_n)
    res_valid |=> !res_valid)
    else begin
      $error("res_valid held longer than one cycle");
      fail_count++;
    end

  busy_a: assert property (@(posedge mclk) disable iff (!rst_n)
    accepted |=> busy)  // unit is occupied right after taking a command
    else begin
      $error("busy low after an accepted command");
      fail_count++;
    end

  // unit takes a new command on the edge that raises res_valid
  free_a: assert property (@(posedge mclk) disable iff (!rst_n)
    $past(accepted, `MULT_LATENCY) |-> !busy)
    else begin
      $error("busy still high when the next command should be taken");
      fail_count++;
    end

  // first sample with reset released still shows the reset state
  reset_a: assert property (@(posedge mclk) $rose(rst_n) |-> !busy && !res_valid)
    else begin
      $error("busy or res_valid high coming out of reset");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== design/mult_unit.sv ====
// top level of the sequential booth multiplier, decode, control, datapath and result
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_unit (
  input  wire                       mclk,
  input  wire                       rst_n,
  input  wire                       cmd_valid,
  input  wire mult_pkg::mult_cmd_t  cmd,
  output wire                       busy,       // source must hold off while high
  output wire                       res_valid,
  output wire mult_pkg::mult_res_t  res
);

  wire                          start;
  wire [`MULT_EXT_WIDTH-1:0]    mcand;
  wire [`MULT_EXT_WIDTH-1:0]    mplier;
  wire [`MULT_TAG_WIDTH-1:0]    tag;
  wire                          prod_lsb;
  wire                          step;
  wire mult_pkg::booth_op_t     booth_op;
  wire                          done;
  wire [2*`MULT_WIDTH-1:0]      product;

  mult_decode decode_i (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .done      (done),
    .start     (start),
    .mcand     (mcand),
    .mplier    (mplier),
    .tag       (tag),
    .busy      (busy)
  );

  mult_control control_i (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .start    (start),
    .prod_lsb (prod_lsb),
    .step     (step),
    .booth_op (booth_op),
    .done     (done)
  );

  booth_datapath datapath_i (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .start    (start),
    .mcand    (mcand),
    .mplier   (mplier),
    .step     (step),
    .booth_op (booth_op),
    .prod_lsb (prod_lsb),
    .product  (product)
  );

  mult_result result_i (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .done      (done),
    .product   (product),
    .tag       (tag),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

`default_nettype wire

// ==== design/mult_result.sv ====
// result capture into hi and lo words plus tag, and the res_valid strobe
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_result (
  input  wire                            mclk,
  input  wire                            rst_n,
  input  wire                            done,       // product register is final
  input  wire [2*`MULT_WIDTH-1:0]        product,
  input  wire [`MULT_TAG_WIDTH-1:0]      tag,        // held by decode
  output logic                           res_valid,  // one-cycle strobe
  output mult_pkg::mult_res_t            res
);

  logic [`MULT_WIDTH-1:0] hi_word;
  logic [`MULT_WIDTH-1:0] lo_word;

  assign hi_word = product[2*`MULT_WIDTH-1:`MULT_WIDTH];
  assign lo_word = product[`MULT_WIDTH-1:0];

  // done is already a single pulse, so the strobe is just its registered copy
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= done;
    end
  end

  // res stays put between results
  always_ff @(posedge mclk) begin
    if (done) begin
      res.hi  <= hi_word;
      res.lo  <= lo_word;
      res.tag <= tag;  // old tag even if a new command lands this same edge
    end
  end

endmodule

`default_nettype wire

// ==== design/booth_datapath.sv ====
// multiplicand register, 66-bit product/multiplier register, add or subtract and shift
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module booth_datapath (
  input  wire                            mclk,
  input  wire                            rst_n,
  input  wire                            start,     // load new operands
  input  wire [`MULT_EXT_WIDTH-1:0]      mcand,
  input  wire [`MULT_EXT_WIDTH-1:0]      mplier,
  input  wire                            step,
  input  wire mult_pkg::booth_op_t       booth_op,
  output logic                           prod_lsb,
  output logic [2*`MULT_WIDTH-1:0]       product    // low 64 bits of the register
);

  localparam int EW = `MULT_EXT_WIDTH;

  logic [EW-1:0]   mcand_q;
  // upper half accumulates partial products
  // lower half starts as the multiplier and is shifted out bit by bit
  logic [2*EW-1:0] prod_q;
  logic [EW:0]     hi_ext;     // upper half plus one sign bit
  logic [EW:0]     addend;
  logic [EW:0]     sum;
  logic [2*EW:0]   pre_shift;  // 67 bits, sum on top of the multiplier half

  // extra bit keeps add and subtract free of overflow
  assign hi_ext = {prod_q[2*EW-1], prod_q[2*EW-1 -: EW]};
  assign addend = booth_op.add_zero ? '0 : {mcand_q[EW-1], mcand_q};

  always_comb begin
    if (booth_op.do_sub) begin
      sum = hi_ext - addend;
    end else begin
      sum = hi_ext + addend;  // plain add or add zero
    end
  end

  assign pre_shift = {sum, prod_q[EW-1:0]};

  // multiplicand is only read after a start has loaded it
  always_ff @(posedge mclk) begin
    if (start) begin
      mcand_q <= mcand;
    end
  end

  // the control FSM reads prod_lsb, so this register gets a defined reset value
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      prod_q <= '0;
    end else if (start) begin
      prod_q <= {{EW{1'b0}}, mplier};  // upper half cleared
    end else if (step) begin
      // dropping bit 0 is the arithmetic shift right, sum's sign fills the top
      prod_q <= pre_shift[2*EW:1];
    end
  end

  assign prod_lsb = prod_q[0];
  assign product  = prod_q[2*`MULT_WIDTH-1:0];  // two guard bits above are not returned

endmodule

`default_nettype wire

// ==== design/mult_control.sv ====
// booth step counter, previous-bit memory, operation select and done pulse
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_control (
  input  wire                  mclk,
  input  wire                  rst_n,
  input  wire                  start,     // clears the sequence like a second reset
  input  wire                  prod_lsb,  // current low bit of the product register
  output logic                 step,      // advance the datapath one iteration
  output mult_pkg::booth_op_t  booth_op,
  output logic                 done       // single pulse once all steps are in
);

  localparam int CNT_W = $clog2(`MULT_STEPS + 1);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MULT_STEPS - 1);
  localparam logic [CNT_W-1:0] ALL_STEPS = CNT_W'(`MULT_STEPS);

  logic [CNT_W-1:0] count;     // steps taken so far
  logic             running;   // iterations still to go
  logic             prev_lsb;  // low bit seen on the previous step
  logic             cnt_full;
  logic             done_q;    // cnt_full delayed by one cycle

  // start and rst_n both wipe the sequence state
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= '0;
      running  <= 1'b0;
      prev_lsb <= 1'b0;
      done_q   <= 1'b0;
    end else if (start) begin
      count    <= '0;
      running  <= 1'b1;
      prev_lsb <= 1'b0;  // implicit bit right of the multiplier
      done_q   <= 1'b0;
    end else begin
      done_q <= cnt_full;
      if (running) begin
        count    <= count + CNT_W'(1);
        prev_lsb <= prod_lsb;     // remembered before the shift moves it out
        if (count == LAST_STEP) begin
          running <= 1'b0;        // this is the final step
        end
      end
    end
  end

  assign step = running;

  // counter parks at ALL_STEPS until the next start
  assign cnt_full = (count == ALL_STEPS);

  // staggered edge detect, high only in the first cycle of cnt_full
  assign done = cnt_full & ~done_q;

  // booth radix-2 recoding on the pair {lsb, prev}
  assign booth_op.add_zero = (prod_lsb == prev_lsb);  // 00 or 11
  assign booth_op.do_sub   = prod_lsb & ~prev_lsb;    // 10

endmodule

`default_nettype wire

// ==== design/mult_decode.sv ====
// command intake, operand extension, tag holding and the busy flag
`timescale 1ns/10ps
`default_nettype none

`include "mult_cfg.svh"

module mult_decode (
  input  wire                            mclk,
  input  wire                            rst_n,
  input  wire                            cmd_valid,  // one-cycle strobe
  input  wire mult_pkg::mult_cmd_t       cmd,
  input  wire                            done,       // last booth step finished
  output logic                           start,      // one-cycle pulse to control and datapath
  output logic [`MULT_EXT_WIDTH-1:0]     mcand,
  output logic [`MULT_EXT_WIDTH-1:0]     mplier,
  output logic [`MULT_TAG_WIDTH-1:0]     tag,
  output logic                           busy
);

  logic                       busy_q;     // a command is in flight
  logic                       accept;
  logic                       sign_ext;
  logic [`MULT_EXT_WIDTH-1:0] a_ext;
  logic [`MULT_EXT_WIDTH-1:0] b_ext;

  // busy drops in the done cycle so the source can issue back to back
  assign busy   = busy_q & ~done;
  assign accept = cmd_valid & ~busy;  // strobes while busy are simply lost

  // mult copies the top bit into the guard bit, multu leaves it zero
  assign sign_ext = (cmd.op == mult_pkg::op_mult);
  assign a_ext    = {sign_ext & cmd.a[`MULT_WIDTH-1], cmd.a};
  assign b_ext    = {sign_ext & cmd.b[`MULT_WIDTH-1], cmd.b};

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      start  <= 1'b0;
    end else begin
      start <= accept;
      if (accept) begin
        busy_q <= 1'b1;  // also covers a new command in the done cycle
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // operands and tag only move on an accepted command
  always_ff @(posedge mclk) begin
    if (accept) begin
      mcand  <= a_ext;
      mplier <= b_ext;
      tag    <= cmd.tag;  // held for the result stage until the next command
    end
  end

endmodule

`default_nettype wire

// ==== design/mult_pkg.sv ====
// opcode enum, command struct, booth operation struct and result struct
`default_nettype none

`include "mult_cfg.svh"

package mult_pkg;

  // multiply flavour
  // only changes how decode extends the operands
  typedef enum logic [0:0] {
    op_mult  = 1'b0,  // signed, sign extend to 33 bits
    op_multu = 1'b1   // unsigned, zero extend to 33 bits
  } mult_op_e;

  // command word presented with cmd_valid, 69 bits
  typedef struct packed {
    mult_op_e                   op;
    logic [`MULT_WIDTH-1:0]     a;    // multiplicand
    logic [`MULT_WIDTH-1:0]     b;    // multiplier
    logic [`MULT_TAG_WIDTH-1:0] tag;  // echoed back in the result
  } mult_cmd_t;

  // per-step action chosen by the controller
  //   add_zero  do_sub
  //      1        0     lsb == prev, nothing to add
  //      0        1     lsb 1 prev 0, start of a run of ones
  //      0        0     lsb 0 prev 1, end of a run of ones
  typedef struct packed {
    logic add_zero;  // addend forced to zero
    logic do_sub;    // subtract the multiplicand instead of adding
  } booth_op_t;

  // finished product split into words, 68 bits
  typedef struct packed {
    logic [`MULT_WIDTH-1:0]     hi;   // product bits 63:32
    logic [`MULT_WIDTH-1:0]     lo;   // product bits 31:0
    logic [`MULT_TAG_WIDTH-1:0] tag;
  } mult_res_t;

endpackage

`default_nettype wire

// ==== design/mult_cfg.svh ====
// width, step count and latency macros for the booth multiplier unit
`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

// operand width as seen on the command port
`define MULT_WIDTH      32

// one guard bit on top so multu operands stay positive in a signed datapath
`define MULT_EXT_WIDTH  33

`define MULT_STEPS      33  // one radix-2 step per extended multiplier bit

// edge that samples cmd_valid to the edge that raises res_valid
// decode 1 + load 1 + steps 33
`define MULT_LATENCY    35

`define MULT_TAG_WIDTH  4   // caller's id, returned with the product

`endif
